/* Makefile */
.PHONY: all run lint clean

all: run

obj_dir/Vtb_top: flist.f $(wildcard source/*.sv test/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_top -Mdir obj_dir

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top +verilator+error+limit+100 | tee sim.log
	grep -q "^Test OK$$" sim.log

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module tb_top

clean:
	rm -rf obj_dir sim.log

/* flist.f */
source/wrap_pkg.sv
source/duplex_core.sv
source/range_reader.sv
source/output_writer.sv
source/mem_arbiter.sv
source/wrap_control.sv
source/wrap_engine_top.sv
test/wrap_properties.sv
test/wrap_checker.sv
test/tb_top.sv

/* source/duplex_core.sv */
`timescale 1ns/1ps

module duplex_core #(
    parameter int ROUNDS = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 op_valid,
    input  wrap_pkg::duplex_op_t op,
    input  wrap_pkg::word_t      op_data,
    input  wrap_pkg::key_t       key,
    output logic                 core_busy,
    output wrap_pkg::word_t      out_word
);

    localparam int CNT_W = (ROUNDS > 1) ? $clog2(ROUNDS) : 1;

    // lanes packed as {a, b, c, d}
    wrap_pkg::key_t  st;
    wrap_pkg::key_t  st_in;
    wrap_pkg::word_t out_in;
    logic [CNT_W-1:0] round_cnt;

    function automatic wrap_pkg::word_t rotl(input wrap_pkg::word_t x, input int n);
        rotl = (x << n) | (x >> (wrap_pkg::WORD_W - n));
    endfunction

    function automatic wrap_pkg::key_t round_fn(input wrap_pkg::key_t s, input wrap_pkg::word_t r);
        wrap_pkg::word_t a;
        wrap_pkg::word_t b;
        wrap_pkg::word_t c;
        wrap_pkg::word_t d;
        {a, b, c, d} = s;
        a = a + b;
        d = rotl(d ^ a, 5);
        c = c + d;
        b = rotl(b ^ c, 9);
        a = a ^ r;
        round_fn = {b, c, d, a};
    endfunction

    // input step applied before the permutation
    always_comb
    begin
        st_in = st;
        out_in = out_word;
        case (op)
            wrap_pkg::OP_INIT:       st_in = key;
            wrap_pkg::OP_ABSORB:     st_in[63:48] = st[63:48] ^ op_data;
            wrap_pkg::OP_FINAL_AD:   st_in[15:0] = st[15:0] ^ 16'd1;
            wrap_pkg::OP_FINAL_BODY: st_in[15:0] = st[15:0] ^ 16'd2;
            wrap_pkg::OP_ENCRYPT:
            begin
                out_in = st[63:48] ^ op_data;
                st_in[63:48] = st[63:48] ^ op_data;
            end
            wrap_pkg::OP_DECRYPT:
            begin
                out_in = st[63:48] ^ op_data;
                st_in[63:48] = op_data;
            end
            wrap_pkg::OP_SQUEEZE:    out_in = st[63:48];
            default:                 st_in = st;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            core_busy <= 1'b0;
            round_cnt <= '0;
        end
        else if (core_busy)
        begin
            st <= round_fn(st, wrap_pkg::word_t'(round_cnt));
            if (round_cnt == CNT_W'(ROUNDS - 1))
                core_busy <= 1'b0;
            else
                round_cnt <= round_cnt + 1'b1;
        end
        else if (op_valid)
        begin
            st <= st_in;
            out_word <= out_in;
            core_busy <= 1'b1;
            round_cnt <= '0;
        end
    end

endmodule

/* source/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic               clk,
    input  logic               reset,
    input  wrap_pkg::mem_req_t rd_req,
    input  wrap_pkg::mem_req_t wr_req,
    output logic               rd_gnt,
    output logic               wr_gnt,
    output wrap_pkg::mem_req_t mem,
    input  wrap_pkg::word_t    mem_rdata,
    output logic               rd_valid,
    output wrap_pkg::word_t    rd_data
);

    logic rd_issued;

    // writer wins and the reader waits a cycle
    assign wr_gnt = wr_req.en;
    assign rd_gnt = rd_req.en && !wr_req.en;

    assign mem = wr_req.en ? wr_req : rd_req;

    always_ff @(posedge clk)
    begin
        if (reset)
            rd_issued <= 1'b0;
        else
            rd_issued <= rd_gnt;
    end

    // memory answers one cycle after the read
    assign rd_valid = rd_issued;
    assign rd_data = mem_rdata;

endmodule

/* source/output_writer.sv */
`timescale 1ns/1ps

module output_writer (
    input  logic               clk,
    input  logic               reset,
    input  logic               load,
    input  wrap_pkg::word_t    base,
    input  logic               put,
    input  wrap_pkg::word_t    data,
    output wrap_pkg::mem_req_t req,
    input  logic               gnt,
    output logic               put_done
);

    wrap_pkg::word_t addr;
    wrap_pkg::word_t data_r;
    logic            pending;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            addr <= '0;
            pending <= 1'b0;
        end
        else if (load)
            addr <= base;
        else if (pending && gnt)
        begin
            pending <= 1'b0;
            addr <= addr + wrap_pkg::word_t'(wrap_pkg::ADDR_STEP);
        end
        else if (put)
            pending <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (put && !pending)
            data_r <= data;
    end

    // full-word write on both byte strobes
    assign req = '{en: pending, wr: pending ? 2'b11 : 2'b00, addr: addr, wdata: data_r};

    assign put_done = pending && gnt;

endmodule

/* source/range_reader.sv */
`timescale 1ns/1ps

module range_reader (
    input  logic               clk,
    input  logic               reset,
    input  logic               load,
    input  wrap_pkg::word_t    base,
    input  wrap_pkg::word_t    limit,
    input  logic               next,
    output logic               empty,
    output wrap_pkg::mem_req_t req,
    input  logic               gnt,
    input  logic               rd_valid,
    input  wrap_pkg::word_t    rd_data,
    output logic               word_valid,
    output wrap_pkg::word_t    word
);

    wrap_pkg::word_t addr;
    wrap_pkg::word_t limit_r;
    logic            pending;

    assign empty = !(addr < limit_r);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            addr <= '0;
            limit_r <= '0;
            pending <= 1'b0;
        end
        else if (load)
        begin
            addr <= base;
            limit_r <= limit;
        end
        else if (pending && gnt)
        begin
            pending <= 1'b0;
            addr <= addr + wrap_pkg::word_t'(wrap_pkg::ADDR_STEP);
        end
        else if (next)
            pending <= 1'b1;
    end

    // read request held until the arbiter lets it through
    assign req = '{en: pending, wr: 2'b00, addr: addr, wdata: '0};

    assign word_valid = rd_valid;
    assign word = rd_data;

endmodule

/* source/wrap_control.sv */
`timescale 1ns/1ps

module wrap_control (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  wrap_pkg::cmd_t       cmd,
    output logic                 busy,
    output logic                 done,
    output logic                 ok,
    output logic                 op_valid,
    output wrap_pkg::duplex_op_t op,
    output wrap_pkg::word_t      op_data,
    input  logic                 core_busy,
    input  wrap_pkg::word_t      out_word,
    output logic                 rd_load,
    output wrap_pkg::word_t      rd_base,
    output wrap_pkg::word_t      rd_limit,
    output logic                 rd_next,
    input  logic                 rd_empty,
    input  logic                 word_valid,
    input  wrap_pkg::word_t      word,
    output logic                 wr_load,
    output wrap_pkg::word_t      wr_base,
    output logic                 wr_put,
    output wrap_pkg::word_t      wr_data,
    input  logic                 put_done
);

    localparam int TAG_CNT_W = $clog2(wrap_pkg::TAG_WORDS);

    typedef enum logic [4:0] {
        S_IDLE, S_INIT, S_AD_NEXT, S_AD_FETCH, S_AD_WAIT,
        S_FINAL_AD, S_FAD_WAIT, S_BODY_NEXT, S_BODY_FETCH, S_BODY_WAIT,
        S_BODY_PUT, S_FINAL_BODY, S_FB_WAIT, S_SQUEEZE, S_SQ_WAIT,
        S_TAG_PUT, S_TAG_FETCH
    } state_t;

    state_t               state;
    state_t               next_state;
    wrap_pkg::cmd_t       cmd_r;
    logic [TAG_CNT_W-1:0] tag_cnt;
    logic                 tag_last;
    logic                 tag_inc;
    logic                 finish;
    logic                 pass;

    assign busy = (state != S_IDLE);
    assign tag_last = (tag_cnt == TAG_CNT_W'(wrap_pkg::TAG_WORDS - 1));

    always_comb
    begin
        next_state = state;
        op_valid = 1'b0;
        op = wrap_pkg::OP_INIT;
        op_data = word;
        rd_load = 1'b0;
        rd_base = cmd_r.ad_start;
        rd_limit = cmd_r.ad_end;
        rd_next = 1'b0;
        wr_load = 1'b0;
        wr_base = cmd_r.out_start;
        wr_put = 1'b0;
        wr_data = out_word;
        tag_inc = 1'b0;
        finish = 1'b0;
        pass = 1'b1;
        case (state)
            S_IDLE:
                if (start)
                    next_state = S_INIT;
            S_INIT:
            begin
                op_valid = 1'b1;
                rd_load = 1'b1;
                next_state = S_AD_WAIT;
            end
            S_AD_NEXT:
                if (rd_empty)
                    next_state = S_FINAL_AD;
                else
                begin
                    rd_next = 1'b1;
                    next_state = S_AD_FETCH;
                end
            S_AD_FETCH:
                if (word_valid)
                begin
                    op_valid = 1'b1;
                    op = wrap_pkg::OP_ABSORB;
                    next_state = S_AD_WAIT;
                end
            S_AD_WAIT:
                if (!core_busy)
                    next_state = S_AD_NEXT;
            S_FINAL_AD:
            begin
                op_valid = 1'b1;
                op = wrap_pkg::OP_FINAL_AD;
                rd_load = 1'b1;
                rd_base = cmd_r.body_start;
                rd_limit = cmd_r.body_end;
                wr_load = 1'b1;
                next_state = S_FAD_WAIT;
            end
            S_FAD_WAIT:
                if (!core_busy)
                    next_state = S_BODY_NEXT;
            S_BODY_NEXT:
                if (rd_empty)
                    next_state = S_FINAL_BODY;
                else
                begin
                    rd_next = 1'b1;
                    next_state = S_BODY_FETCH;
                end
            S_BODY_FETCH:
                if (word_valid)
                begin
                    op_valid = 1'b1;
                    op = cmd_r.unwrap ? wrap_pkg::OP_DECRYPT : wrap_pkg::OP_ENCRYPT;
                    next_state = S_BODY_WAIT;
                end
            S_BODY_WAIT:
                if (!core_busy)
                begin
                    wr_put = 1'b1;
                    next_state = S_BODY_PUT;
                end
            S_BODY_PUT:
                if (put_done)
                    next_state = S_BODY_NEXT;
            S_FINAL_BODY:
            begin
                op_valid = 1'b1;
                op = wrap_pkg::OP_FINAL_BODY;
                // tag range serves both the tag writes and the tag reads
                rd_load = 1'b1;
                rd_base = cmd_r.tag_addr;
                rd_limit = cmd_r.tag_addr
                         + wrap_pkg::word_t'(wrap_pkg::TAG_WORDS * wrap_pkg::ADDR_STEP);
                wr_load = 1'b1;
                wr_base = cmd_r.tag_addr;
                next_state = S_FB_WAIT;
            end
            S_FB_WAIT:
                if (!core_busy)
                    next_state = S_SQUEEZE;
            S_SQUEEZE:
            begin
                op_valid = 1'b1;
                op = wrap_pkg::OP_SQUEEZE;
                next_state = S_SQ_WAIT;
            end
            S_SQ_WAIT:
                if (!core_busy && cmd_r.unwrap)
                begin
                    rd_next = 1'b1;
                    next_state = S_TAG_FETCH;
                end
                else if (!core_busy)
                begin
                    wr_put = 1'b1;
                    next_state = S_TAG_PUT;
                end
            S_TAG_PUT:
                if (put_done)
                begin
                    tag_inc = 1'b1;
                    finish = tag_last;
                    next_state = tag_last ? S_IDLE : S_SQUEEZE;
                end
            S_TAG_FETCH:
                if (word_valid && word != out_word)
                begin
                    // first mismatch ends the unwrap
                    finish = 1'b1;
                    pass = 1'b0;
                    next_state = S_IDLE;
                end
                else if (word_valid)
                begin
                    tag_inc = 1'b1;
                    finish = tag_last;
                    next_state = tag_last ? S_IDLE : S_SQUEEZE;
                end
            default:
                next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= S_IDLE;
            done <= 1'b0;
            ok <= 1'b0;
            tag_cnt <= '0;
        end
        else
        begin
            state <= next_state;
            done <= finish;
            if (finish)
                ok <= pass;
            if (state == S_FINAL_BODY)
                tag_cnt <= '0;
            else if (tag_inc)
                tag_cnt <= tag_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && start)
            cmd_r <= cmd;
    end

endmodule

/* source/wrap_engine_top.sv */
`timescale 1ns/1ps

module wrap_engine_top #(
    parameter int ROUNDS = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  wrap_pkg::cmd_t     cmd,
    input  wrap_pkg::key_t     key,
    input  wrap_pkg::word_t    mem_rdata,
    output wrap_pkg::mem_req_t mem,
    output logic               busy,
    output logic               done,
    output logic               ok
);

    logic                 op_valid;
    logic                 core_busy;
    wrap_pkg::duplex_op_t op;
    wrap_pkg::word_t      op_data;
    wrap_pkg::word_t      out_word;

    logic                 rd_load;
    logic                 rd_next;
    logic                 rd_empty;
    logic                 word_valid;
    wrap_pkg::word_t      rd_base;
    wrap_pkg::word_t      rd_limit;
    wrap_pkg::word_t      word;

    logic                 wr_load;
    logic                 wr_put;
    logic                 put_done;
    wrap_pkg::word_t      wr_base;
    wrap_pkg::word_t      wr_data;

    // arbiter side
    wrap_pkg::mem_req_t   rd_req;
    wrap_pkg::mem_req_t   wr_req;
    logic                 rd_gnt;
    logic                 wr_gnt;
    logic                 rd_valid;
    wrap_pkg::word_t      rd_data;

    wrap_control control (
        .clk(clk), .reset(reset), .start(start), .cmd(cmd),
        .busy(busy), .done(done), .ok(ok),
        .op_valid(op_valid), .op(op), .op_data(op_data),
        .core_busy(core_busy), .out_word(out_word),
        .rd_load(rd_load), .rd_base(rd_base), .rd_limit(rd_limit), .rd_next(rd_next),
        .rd_empty(rd_empty), .word_valid(word_valid), .word(word),
        .wr_load(wr_load), .wr_base(wr_base), .wr_put(wr_put), .wr_data(wr_data),
        .put_done(put_done)
    );

    duplex_core #(
        .ROUNDS(ROUNDS)
    ) core (
        .clk(clk), .reset(reset), .op_valid(op_valid), .op(op), .op_data(op_data),
        .key(key), .core_busy(core_busy), .out_word(out_word)
    );

    range_reader reader (
        .clk(clk), .reset(reset), .load(rd_load), .base(rd_base), .limit(rd_limit),
        .next(rd_next), .empty(rd_empty), .req(rd_req), .gnt(rd_gnt),
        .rd_valid(rd_valid), .rd_data(rd_data), .word_valid(word_valid), .word(word)
    );

    output_writer writer (
        .clk(clk), .reset(reset), .load(wr_load), .base(wr_base), .put(wr_put),
        .data(wr_data), .req(wr_req), .gnt(wr_gnt), .put_done(put_done)
    );

    mem_arbiter arbiter (
        .clk(clk), .reset(reset), .rd_req(rd_req), .wr_req(wr_req),
        .rd_gnt(rd_gnt), .wr_gnt(wr_gnt), .mem(mem), .mem_rdata(mem_rdata),
        .rd_valid(rd_valid), .rd_data(rd_data)
    );

endmodule

/* source/wrap_pkg.sv */
package wrap_pkg;

    localparam int WORD_W = 16;
    localparam int KEY_W = 64;
    localparam int TAG_WORDS = KEY_W / WORD_W;
    localparam int ADDR_STEP = 2;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [KEY_W-1:0] key_t;

    // range ends are exclusive
    typedef struct packed {
        logic  unwrap;
        word_t ad_start;
        word_t ad_end;
        word_t body_start;
        word_t body_end;
        word_t out_start;
        word_t tag_addr;
    } cmd_t;

    typedef struct packed {
        logic       en;
        logic [1:0] wr;
        word_t      addr;
        word_t      wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        OP_INIT,
        OP_ABSORB,
        OP_FINAL_AD,
        OP_ENCRYPT,
        OP_DECRYPT,
        OP_FINAL_BODY,
        OP_SQUEEZE
    } duplex_op_t;

endpackage

/* test/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    localparam int ROUNDS = 4;
    localparam int TIMEOUT = 4000;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic               clk;
    logic               reset;
    logic               start;
    wrap_pkg::cmd_t     cmd;
    wrap_pkg::key_t     key;
    wrap_pkg::word_t    mem_rdata;
    wrap_pkg::mem_req_t mem;
    logic               busy;
    logic               done;
    logic               ok;

    logic [15:0] mem_array [0:32767];
    logic [31:0] lfsr_state;
    logic [15:0] model_out [0:7];
    logic [15:0] model_tag [0:3];
    int          timeouts;

    wrap_engine_top #(
        .ROUNDS(ROUNDS)
    ) UUT (
        .clk(clk), .reset(reset), .start(start), .cmd(cmd), .key(key),
        .mem_rdata(mem_rdata), .mem(mem), .busy(busy), .done(done), .ok(ok)
    );

    wrap_checker check (
        .clk(clk), .reset(reset), .mem(mem), .busy(busy), .done(done), .ok(ok)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory port with read data one cycle later
    always @(posedge clk)
    begin
        if (mem.en && mem.wr != 2'b00)
        begin
            if (mem.wr[0])
                mem_array[mem.addr[15:1]][7:0] = mem.wdata[7:0];
            if (mem.wr[1])
                mem_array[mem.addr[15:1]][15:8] = mem.wdata[15:8];
        end
        else if (mem.en)
            mem_rdata <= mem_array[mem.addr[15:1]];
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            lfsr_step = (s >> 1) ^ LFSR_TAPS;
        else
            lfsr_step = s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic draw(input int n, output logic [63:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic logic [15:0] rotate_left(input logic [15:0] x, input int n);
        rotate_left = (x << n) | (x >> (16 - n));
    endfunction

    function automatic logic [63:0] permute(input logic [63:0] s);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        logic [15:0] d;
        int          r;
        {a, b, c, d} = s;
        for (r = 0; r < ROUNDS; r++)
        begin
            a = a + b;
            d = rotate_left(d ^ a, 5);
            c = c + d;
            b = rotate_left(b ^ c, 9);
            a = a ^ r[15:0];
            {a, b, c, d} = {b, c, d, a};
        end
        permute = {a, b, c, d};
    endfunction

    // expected writes and ok for one command from current memory
    task automatic model_command(input wrap_pkg::cmd_t c, input wrap_pkg::key_t k);
        logic [63:0] st;
        logic [15:0] addr;
        logic [15:0] w;
        logic [15:0] res;
        logic        exp_ok;
        int          n;
        st = permute(k);
        for (addr = c.ad_start; addr < c.ad_end; addr = addr + 16'd2)
        begin
            st[63:48] = st[63:48] ^ mem_array[addr[15:1]];
            st = permute(st);
        end
        st[15:0] = st[15:0] ^ 16'd1;
        st = permute(st);
        n = 0;
        for (addr = c.body_start; addr < c.body_end; addr = addr + 16'd2)
        begin
            w = mem_array[addr[15:1]];
            res = st[63:48] ^ w;
            st[63:48] = c.unwrap ? w : res;
            st = permute(st);
            model_out[n] = res;
            check.push_write(c.out_start + 16'(2 * n), res);
            n++;
        end
        st[15:0] = st[15:0] ^ 16'd2;
        st = permute(st);
        exp_ok = 1'b1;
        for (n = 0; n < wrap_pkg::TAG_WORDS && exp_ok; n++)
        begin
            res = st[63:48];
            st = permute(st);
            addr = c.tag_addr + 16'(2 * n);
            model_tag[n] = res;
            if (!c.unwrap)
                check.push_write(addr, res);
            else if (mem_array[addr[15:1]] != res)
                exp_ok = 1'b0;
        end
        check.push_done(exp_ok);
    endtask

    task automatic fill_random(input logic [15:0] base, input int count);
        logic [63:0] v;
        int          i;
        for (i = 0; i < count; i++)
        begin
            draw(16, v);
            mem_array[base[15:1] + 15'(i)] = v[15:0];
        end
    endtask

    task automatic run_command(input string name, input wrap_pkg::cmd_t c,
                               input wrap_pkg::key_t k);
        wrap_pkg::cmd_t other;
        int             waited;
        check.set_test(name);
        model_command(c, k);
        @(posedge clk);
        start <= 1'b1;
        cmd <= c;
        key <= k;
        @(posedge clk);
        start <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!busy && waited < TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!busy)
        begin
            $display("%s: busy never rose after start", name);
            timeouts++;
            return;
        end
        // a start while busy has to be ignored
        other = c;
        other.unwrap = !c.unwrap;
        other.out_start = c.out_start ^ 16'h0800;
        @(posedge clk);
        start <= 1'b1;
        cmd <= other;
        @(posedge clk);
        start <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!done && waited < TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!done)
        begin
            $display("%s: no done within %0d cycles", name, TIMEOUT);
            timeouts++;
        end
        else
        begin
            @(posedge clk);
            check.finish_command();
        end
    endtask

    // wrap, good unwrap, then unwrap with a spoiled tag
    task automatic run_iteration(input int iter);
        logic [63:0]    v;
        wrap_pkg::key_t k;
        wrap_pkg::cmd_t c;
        logic [15:0]    off;
        logic [15:0]    flip;
        int             ad_len;
        int             body_len;
        int             i;
        draw(64, v);
        k = v;
        draw(3, v);
        ad_len = int'(v[2:0]) % 7;
        draw(3, v);
        body_len = int'(v[2:0]) % 7;
        // iterations 1 to 3 cover the empty ranges
        if (iter == 1 || iter == 3)
            ad_len = 0;
        if (iter == 2 || iter == 3)
            body_len = 0;
        draw(4, v);
        off = 16'(iter * 256) + {11'd0, v[3:0], 1'b0};
        c.unwrap = 1'b0;
        c.ad_start = 16'h1000 + off;
        c.ad_end = c.ad_start + 16'(2 * ad_len);
        c.body_start = 16'h2000 + off;
        c.body_end = c.body_start + 16'(2 * body_len);
        c.out_start = 16'h3000 + off;
        c.tag_addr = 16'h4000 + off;
        fill_random(c.ad_start, ad_len);
        fill_random(c.body_start, body_len);
        run_command($sformatf("wrap %0d", iter), c, k);
        if (timeouts != 0)
            return;
        c.unwrap = 1'b1;
        c.body_start = 16'h5000 + off;
        c.body_end = c.body_start + 16'(2 * body_len);
        c.out_start = 16'h7000 + off;
        c.tag_addr = 16'h6000 + off;
        for (i = 0; i < body_len; i++)
            mem_array[c.body_start[15:1] + 15'(i)] = model_out[i];
        for (i = 0; i < wrap_pkg::TAG_WORDS; i++)
            mem_array[c.tag_addr[15:1] + 15'(i)] = model_tag[i];
        run_command($sformatf("unwrap %0d", iter), c, k);
        if (timeouts != 0)
            return;
        draw(2, v);
        i = int'(v[1:0]);
        draw(16, v);
        flip = (v[15:0] == 16'd0) ? 16'h0001 : v[15:0];
        mem_array[c.tag_addr[15:1] + 15'(i)] = mem_array[c.tag_addr[15:1] + 15'(i)] ^ flip;
        c.out_start = 16'h8000 + off;
        run_command($sformatf("unwrap bad tag %0d", iter), c, k);
    endtask

    initial
    begin
        int iter;
        int total;
        reset <= 1'b1;
        start <= 1'b0;
        cmd <= '0;
        key <= '0;
        mem_rdata <= '0;
        lfsr_state = 32'd39;
        timeouts = 0;
        for (iter = 0; iter < 32768; iter++)
            mem_array[iter] = {iter[14:0], 1'b0} ^ 16'hC35A;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        for (iter = 0; iter < 8 && timeouts == 0; iter++)
            run_iteration(iter);
        total = check.value_errors + check.order_errors + check.missing_errors
              + UUT.props.fail_count + timeouts;
        $display("errors: value %0d, order %0d, missing %0d, assertion %0d, timeout %0d",
                 check.value_errors, check.order_errors, check.missing_errors,
                 UUT.props.fail_count, timeouts);
        if (total == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* test/wrap_checker.sv */
`timescale 1ns/1ps

module wrap_checker (
    input logic               clk,
    input logic               reset,
    input wrap_pkg::mem_req_t mem,
    input logic               busy,
    input logic               done,
    input logic               ok
);

    logic [15:0] exp_addr[$];
    logic [15:0] exp_data[$];
    logic        exp_ok[$];
    string       test_name = "reset";
    logic        after_reset = 1'b0;
    int          value_errors = 0;
    int          order_errors = 0;
    int          missing_errors = 0;

    task automatic set_test(input string name);
        test_name = name;
    endtask

    task automatic push_write(input logic [15:0] addr, input logic [15:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic push_done(input logic expect_ok);
        exp_ok.push_back(expect_ok);
    endtask

    // called once the command has ended
    task automatic finish_command();
        if (exp_addr.size() != 0)
        begin
            missing_errors++;
            $display("%s: %0d expected writes never happened", test_name, exp_addr.size());
            exp_addr.delete();
            exp_data.delete();
        end
        if (exp_ok.size() != 0)
        begin
            missing_errors++;
            $display("%s: the command ended without its done pulse", test_name);
            exp_ok.delete();
        end
    endtask

    task automatic check_write();
        logic [15:0] ea;
        logic [15:0] ed;
        if (exp_addr.size() == 0)
        begin
            order_errors++;
            $display("%s: unexpected write of %h to address %h", test_name, mem.wdata, mem.addr);
        end
        else
        begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            if (mem.addr != ea || mem.wdata != ed)
            begin
                value_errors++;
                $display("[FAIL] %s: write expected %h at %h, got %h at %h",
                         test_name, ed, ea, mem.wdata, mem.addr);
            end
            if (mem.wr != 2'b11)
            begin
                value_errors++;
                $display("[FAIL] %s: write strobes expected 11, got %b", test_name, mem.wr);
            end
        end
    endtask

    task automatic check_done();
        logic eo;
        if (exp_ok.size() == 0)
        begin
            order_errors++;
            $display("%s: done pulse with no command outstanding", test_name);
        end
        else
        begin
            eo = exp_ok.pop_front();
            if (ok != eo)
            begin
                value_errors++;
                $display("[FAIL] %s: ok expected %0b, got %0b", test_name, eo, ok);
            end
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk)
    begin
        if (reset)
            after_reset = 1'b1;
        else
        begin
            if (after_reset && (busy || done))
            begin
                order_errors++;
                $display("busy or done was high right after reset");
            end
            after_reset = 1'b0;
            if (mem.en && mem.wr != 2'b00)
                check_write();
            if (done)
                check_done();
        end
    end

endmodule

/* test/wrap_properties.sv */
`timescale 1ns/1ps

module wrap_properties (
    input logic               clk,
    input logic               reset,
    input wrap_pkg::mem_req_t mem,
    input logic               busy,
    input logic               done
);

    int fail_count = 0;

    done_single_cycle: assert property (
        @(posedge clk) disable iff (reset) done |=> !done
    ) else
    begin
        fail_count++;
        $error("done stayed high for a second cycle");
    end

    // byte strobes only on an enabled cycle
    strobe_needs_enable: assert property (
        @(posedge clk) disable iff (reset) (mem.wr != 2'b00) |-> mem.en
    ) else
    begin
        fail_count++;
        $error("write strobes set while the memory port is not enabled");
    end

    busy_falls_with_done: assert property (
        @(posedge clk) disable iff (reset) $fell(busy) |-> done
    ) else
    begin
        fail_count++;
        $error("busy fell without a done pulse");
    end

endmodule

bind wrap_engine_top wrap_properties props (
    .clk(clk), .reset(reset), .mem(mem), .busy(busy), .done(done)
);
